//--- verilog.f
hw/fb_bus_pkg.sv
hw/fb_map_pkg.sv
hw/fb_addr_decoder.sv
hw/fb_router.sv
hw/fb_sram.sv
hw/fb_reg_bank.sv
hw/fb_default_slave.sv
hw/fb_subsys_top.sv
tests/fb_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the frontend bus testbench with Verilator, then judges the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fb_subsys_tb \
   -f verilog.f -o fb_subsys_sim > build.log 2>&1 \
   || { cat build.log; echo "Simulation failed" > sim.log; }
[ -f sim.log ] && grep -q "Simulation failed" sim.log \
   || ./obj_dir/fb_subsys_sim > sim.log 2>&1 \
   || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

//--- tests/fb_subsys_tb.sv
// Frontend bus subsystem testbench with reference model, protocol assertions and LFSR traffic
`timescale 1ns/1ps
`default_nettype none

module fb_subsys_tb
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
();

   localparam int SRAM_AW  = 6;
   localparam int REG_WAIT = 3;
   localparam int CLK_NS   = 4;
   localparam int RST_CYC  = 3;
   localparam int IDLE_CYC = 6;
   // Transactions per test
   localparam int N_FILL   = 8;
   localparam int N_SRAM   = 48;
   localparam int N_REGS   = 16;
   localparam int N_DFLT   = 12;
   localparam int N_MIX    = 80;
   localparam int N_TOTAL  = N_FILL + N_SRAM + N_REGS + N_DFLT + N_MIX;
   // Longest wait for the last responses of a test
   localparam int DRAIN_CYC = 4 * (REG_WAIT + 4);
   // Register access plus stalls bounds every transaction
   localparam int WATCHDOG_NS = (N_TOTAL * (REG_WAIT + 4) + RST_CYC + 2 * IDLE_CYC) * CLK_NS;
   localparam logic [31:0] SEED = 32'he5b7_12b9;

   // Expected answer and the slave that owes it
   typedef struct packed {
      int       slv;
      fb_word_t data;
   } exp_t;

   logic        clk;
   logic        arst_n;
   logic        cmd_valid;
   fb_cmd_t     cmd;
   logic        cmd_ready;
   logic        rsp_valid;
   logic        rsp_ready = 1'b0;
   fb_word_t    rsp_data;

   // Reference model state
   fb_word_t    sram_m [2**SRAM_AW];
   fb_word_t    regs_m [4] = '{default: '0};
   exp_t        exp_q [$];
   exp_t        head;
   logic        regs_busy  = 1'b0;
   logic        cmd_seen   = 1'b0;
   logic        stall_en   = 1'b0;
   logic [31:0] lfsr_q     = SEED;
   logic [31:0] stall_lfsr = SEED;
   int          mon_err    = 0;
   int          prop_err   = 0;
   int          main_err   = 0;
   int          txn_cnt    = 0;
   int          txn_mark   = 0;
   int          err_mark   = 0;

   fb_subsys_top #(
      .SRAM_AW  (SRAM_AW),
      .REG_WAIT (REG_WAIT)
   ) fb_subsys_top_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd       (cmd),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_NS / 2) clk = ~clk;
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit
   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   function automatic fb_word_t apply_mask(fb_word_t old_w, fb_word_t new_w, fb_mask_t msk);
      fb_word_t bm;
      bm = {{8{msk[3]}}, {8{msk[2]}}, {8{msk[1]}}, {8{msk[0]}}};
      return (old_w & ~bm) | (new_w & bm);
   endfunction

   function automatic int slave_of(fb_addr_t a);
      if (a[31:28] == REGION_SRAM) begin
         return SLV_SRAM;
      end else if (a[31:28] == REGION_REGS) begin
         return SLV_REGS;
      end
      return SLV_DFLT;
   endfunction

   // Applies one command to the model and returns its answer
   function automatic exp_t model_access(fb_cmd_t c);
      exp_t               e;
      logic [SRAM_AW-1:0] si;
      logic [1:0]         ri;
      e.slv = slave_of(c.addr);
      si    = c.addr[SRAM_AW+1:2];
      ri    = c.addr[3:2];
      if (e.slv == SLV_SRAM) begin
         sram_m[si] = apply_mask(sram_m[si], c.wdata, c.we_msk);
         e.data     = sram_m[si];
      end else if (e.slv == SLV_REGS) begin
         regs_m[ri] = apply_mask(regs_m[ri], c.wdata, c.we_msk);
         e.data     = regs_m[ri];
      end else begin
         // Unmapped writes go nowhere
         e.data = DFLT_WORD;
      end
      return e;
   endfunction

   // Random back-pressure with ready low a quarter of the time
   always @(posedge clk) begin
      if (stall_en) begin
         stall_lfsr = lfsr_step(lfsr_step(stall_lfsr));
         rsp_ready <= ~(stall_lfsr[1] & stall_lfsr[0]);
      end else begin
         rsp_ready <= 1'b1;
      end
   end

   // Handshakes seen mid-cycle where every signal has settled
   always @(negedge clk) begin
      if (arst_n) begin
         if (cmd_valid) begin
            cmd_seen = 1'b1;
         end
         if (regs_busy) begin
            assert (!cmd_ready) else begin
               mon_err++;
               $display("%0t: cmd_ready high while the register bank owns the bus", $time);
            end
         end
         if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
               mon_err++;
               $display("%0t: response seen with no command outstanding", $time);
            end else begin
               head = exp_q.pop_front();
               assert (rsp_data == head.data) else begin
                  mon_err++;
                  $display("mismatch at %0t: rsp_data expected %h actual %h",
                           $time, head.data, rsp_data);
               end
               if (regs_busy) begin
                  assert (head.slv == SLV_REGS) else begin
                     mon_err++;
                     $display("%0t: other response during an open register access", $time);
                  end
                  regs_busy = 1'b0;
               end
            end
         end
         if (cmd_valid && cmd_ready) begin
            head = model_access(cmd);
            exp_q.push_back(head);
            if (head.slv == SLV_REGS) begin
               regs_busy = 1'b1;
            end
         end
      end
   end

   // Response held with stable data under back-pressure
   assert property (@(posedge clk) disable iff (!arst_n)
                    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
   else begin
      prop_err++;
      $display("%0t: response dropped or changed before its handshake", $time);
   end

   // Quiet bus until the first command
   assert property (@(posedge clk) disable iff (!arst_n) !cmd_seen |-> !rsp_valid)
   else begin
      prop_err++;
      $display("%0t: rsp_valid high before any command", $time);
   end

   // Called on a rising edge and returns on the handshake edge
   task automatic send(input fb_addr_t addr, input fb_mask_t msk, input fb_word_t data);
      cmd_valid <= 1'b1;
      cmd       <= {addr, msk, data};
      do begin
         @(negedge clk);
      end while (!cmd_ready);
      @(posedge clk);
      cmd_valid <= 1'b0;
      txn_cnt++;
   endtask

   // Half reads and half writes with a random mask
   task automatic send_random(input int region);
      logic [31:0] a;
      logic [31:0] m;
      logic [31:0] d;
      logic [31:0] rd;
      draw(32, a);
      draw(4, m);
      draw(32, d);
      draw(1, rd);
      if (region == SLV_SRAM) begin
         a[31:28] = REGION_SRAM;
         // Eight words in use and random bits above the index alias
         a[SRAM_AW+1:5] = '0;
      end else if (region == SLV_REGS) begin
         a[31:28] = REGION_REGS;
      end else if (a[31:29] == 3'b000) begin
         a[31] = 1'b1;
      end
      send(a, rd[0] ? 4'h0 : m[3:0], d);
   endtask

   // Waits for every owed response, bounded
   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_CYC) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         main_err++;
         $display("%0t: %0d responses never arrived", $time, exp_q.size());
      end
   endtask

   task automatic report(input string name);
      int errs;
      errs = mon_err + prop_err + main_err;
      $display("test %s done, %0d transactions, %0d errors",
               name, txn_cnt - txn_mark, errs - err_mark);
      txn_mark = txn_cnt;
      err_mark = errs;
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] d;
      int          region;
      arst_n    = 1'b0;
      cmd_valid = 1'b0;
      cmd       = '0;
      repeat (RST_CYC) @(posedge clk);
      arst_n <= 1'b1;
      repeat (IDLE_CYC) @(posedge clk);
      report("reset_idle");

      // Known contents first as unwritten SRAM reads back unknown
      for (int i = 0; i < N_FILL; i++) begin
         draw(32, d);
         send(fb_addr_t'(i << 2), 4'hf, d);
      end
      for (int i = 0; i < N_SRAM; i++) begin
         send_random(SLV_SRAM);
      end
      drain();
      report("sram");

      for (int i = 0; i < N_REGS; i++) begin
         send_random(SLV_REGS);
      end
      drain();
      report("regs");

      for (int i = 0; i < N_DFLT; i++) begin
         send_random(SLV_DFLT);
      end
      drain();
      report("unmapped");

      // Interleaved slaves with stalls
      // Reads also catch stray unmapped writes
      stall_en <= 1'b1;
      for (int i = 0; i < N_MIX; i++) begin
         draw(2, r);
         region = (r[1:0] == 2'd3) ? SLV_DFLT : int'(r[1:0]);
         send_random(region);
      end
      drain();
      stall_en <= 1'b0;
      // Quiet tail where a duplicated response meets an empty queue
      repeat (IDLE_CYC) @(posedge clk);
      report("mixed");

      $display("tests 5, transactions %0d, errors %0d", txn_cnt, mon_err + prop_err + main_err);
      if (mon_err + prop_err + main_err == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired with %0d responses outstanding", exp_q.size());
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/fb_subsys_top.sv
// Frontend bus subsystem: decoder, router, SRAM, register bank and default slave
`timescale 1ns/1ps
`default_nettype none

module fb_subsys_top
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
#(
   parameter int SRAM_AW  = 6,
   parameter int REG_WAIT = 3
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     cmd_valid,
   output logic     cmd_ready,
   input  fb_cmd_t  cmd,
   output logic     rsp_valid,
   input  logic     rsp_ready,
   output fb_word_t rsp_data
);

   fb_sel_t                sel;
   fb_sel_t                slv_cmd_valid;
   fb_sel_t                slv_cmd_ready;
   fb_sel_t                slv_rsp_valid;
   fb_sel_t                slv_rsp_ready;
   fb_word_t [FB_NBUS-1:0] slv_rsp_data;

   // Memory map
   fb_addr_decoder fb_addr_decoder_inst (
      .addr (cmd.addr),
      .sel  (sel)
   );

   // Bus ownership and response merge
   fb_router fb_router_inst (
      .clk           (clk),
      .arst_n        (arst_n),
      .sel           (sel),
      .cmd_valid     (cmd_valid),
      .cmd_ready     (cmd_ready),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp_data      (rsp_data),
      .slv_cmd_valid (slv_cmd_valid),
      .slv_cmd_ready (slv_cmd_ready),
      .slv_rsp_valid (slv_rsp_valid),
      .slv_rsp_ready (slv_rsp_ready),
      .slv_rsp_data  (slv_rsp_data)
   );

   // Command struct fans out unchanged to all slaves
   fb_sram #(
      .SRAM_AW (SRAM_AW)
   ) fb_sram_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd_valid (slv_cmd_valid[SLV_SRAM]),
      .cmd_ready (slv_cmd_ready[SLV_SRAM]),
      .cmd       (cmd),
      .rsp_valid (slv_rsp_valid[SLV_SRAM]),
      .rsp_ready (slv_rsp_ready[SLV_SRAM]),
      .rsp_data  (slv_rsp_data[SLV_SRAM])
   );

   fb_reg_bank #(
      .REG_WAIT (REG_WAIT)
   ) fb_reg_bank_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd_valid (slv_cmd_valid[SLV_REGS]),
      .cmd_ready (slv_cmd_ready[SLV_REGS]),
      .cmd       (cmd),
      .rsp_valid (slv_rsp_valid[SLV_REGS]),
      .rsp_ready (slv_rsp_ready[SLV_REGS]),
      .rsp_data  (slv_rsp_data[SLV_REGS])
   );

   fb_default_slave fb_default_slave_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd_valid (slv_cmd_valid[SLV_DFLT]),
      .cmd_ready (slv_cmd_ready[SLV_DFLT]),
      .cmd       (cmd),
      .rsp_valid (slv_rsp_valid[SLV_DFLT]),
      .rsp_ready (slv_rsp_ready[SLV_DFLT]),
      .rsp_data  (slv_rsp_data[SLV_DFLT])
   );

endmodule

`default_nettype wire

//--- hw/fb_default_slave.sv
// Default slave: answers every unmapped access with a fixed word
`timescale 1ns/1ps
`default_nettype none

module fb_default_slave
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     cmd_valid,
   output logic     cmd_ready,
   input  fb_cmd_t  cmd,
   output logic     rsp_valid,
   input  logic     rsp_ready,
   output fb_word_t rsp_data
);

   // Response owed to the master
   logic pend;

   // Only one answer outstanding
   assign cmd_ready = ~pend;
   assign rsp_valid = pend;
   // Command content never matters here, writes go nowhere
   assign rsp_data  = DFLT_WORD;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend <= 1'b0;
      end else if (cmd_valid && cmd_ready) begin
         pend <= 1'b1;
      end else if (rsp_valid && rsp_ready) begin
         pend <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- hw/fb_reg_bank.sv
// Register bank slave: four scratch words answering after programmable wait cycles
`timescale 1ns/1ps
`default_nettype none

module fb_reg_bank
   import fb_bus_pkg::*;
#(
   parameter int REG_WAIT = 3
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     cmd_valid,
   output logic     cmd_ready,
   input  fb_cmd_t  cmd,
   output logic     rsp_valid,
   input  logic     rsp_ready,
   output fb_word_t rsp_data
);

   // Wait counter, at least one bit wide
   typedef logic [$clog2(REG_WAIT+2)-1:0] wait_cnt_t;
   // Register index, address bits 3 to 2
   typedef logic [1:0] reg_idx_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_RESP
   } state_t;

   // Counter load, last wait cycle at zero
   localparam wait_cnt_t WAIT_LAST = wait_cnt_t'((REG_WAIT > 0) ? REG_WAIT - 1 : 0);

   state_t    state;
   wait_cnt_t cnt;
   reg_idx_t  idx;
   reg_idx_t  idx_q;
   fb_word_t  regs [4];
   logic      hs_cmd;
   logic      hs_rsp;

   assign idx    = cmd.addr[3:2];
   assign hs_cmd = cmd_valid & cmd_ready;
   assign hs_rsp = rsp_valid & rsp_ready;

   // One access in flight
   assign cmd_ready = (state == ST_IDLE);
   assign rsp_valid = (state == ST_RESP);
   // Register holds still until the response handshake
   assign rsp_data  = regs[idx_q];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
         idx_q <= '0;
         for (int r = 0; r < 4; r++) begin
            regs[r] <= '0;
         end
      end else begin
         case (state)
            ST_IDLE: begin
               if (hs_cmd) begin
                  // Write lands at once, answer waits
                  regs[idx] <= fb_merge(regs[idx], cmd.wdata, cmd.we_msk);
                  idx_q     <= idx;
                  cnt       <= WAIT_LAST;
                  state     <= (REG_WAIT == 0) ? ST_RESP : ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (cnt == '0) begin
                  state <= ST_RESP;
               end else begin
                  cnt <= cnt - wait_cnt_t'(1);
               end
            end
            ST_RESP: begin
               if (hs_rsp) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/fb_sram.sv
// SRAM slave: word memory with byte-masked writes and a one-entry response register
`timescale 1ns/1ps
`default_nettype none

module fb_sram
   import fb_bus_pkg::*;
#(
   parameter int SRAM_AW = 6
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     cmd_valid,
   output logic     cmd_ready,
   input  fb_cmd_t  cmd,
   output logic     rsp_valid,
   input  logic     rsp_ready,
   output fb_word_t rsp_data
);

   localparam int DEPTH = 2**SRAM_AW;

   // Word index within the SRAM
   typedef logic [SRAM_AW-1:0] sram_idx_t;

   fb_word_t  mem [DEPTH];
   sram_idx_t idx;
   fb_word_t  merged;
   logic      hs_cmd;
   logic      hs_rsp;

   // Bits above the index alias
   assign idx = cmd.addr[SRAM_AW+1:2];

   assign hs_cmd = cmd_valid & cmd_ready;
   assign hs_rsp = rsp_valid & rsp_ready;

   // Room when empty or draining this cycle
   assign cmd_ready = ~rsp_valid | rsp_ready;

   // Word as it reads after the write
   // Zero mask leaves it unchanged, so reads fall out of the same path
   assign merged = fb_merge(mem[idx], cmd.wdata, cmd.we_msk);

   // Storage and response data
   always_ff @(posedge clk) begin
      if (hs_cmd) begin
         mem[idx] <= merged;
         rsp_data <= merged;
      end
   end

   // Response entry occupancy
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid <= 1'b0;
      end else if (hs_cmd) begin
         rsp_valid <= 1'b1;
      end else if (hs_rsp) begin
         rsp_valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- hw/fb_router.sv
// Bus router: per-slave bus-cycle flags, command gating and response merging
`timescale 1ns/1ps
`default_nettype none

module fb_router
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   // Decoded target of the current command
   input  fb_sel_t                sel,
   // Master side
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   output logic                   rsp_valid,
   input  logic                   rsp_ready,
   output fb_word_t               rsp_data,
   // Slave side
   output fb_sel_t                slv_cmd_valid,
   input  fb_sel_t                slv_cmd_ready,
   input  fb_sel_t                slv_rsp_valid,
   output fb_sel_t                slv_rsp_ready,
   input  fb_word_t [FB_NBUS-1:0] slv_rsp_data
);

   // Slave currently holding the bus
   fb_sel_t pending;
   // Handshakes per slave
   fb_sel_t hs_cmd;
   fb_sel_t hs_rsp;
   // Per-slave ready seen by the master
   fb_sel_t cmd_ready_sel;
   // Bus free or held by that slave
   fb_sel_t accept;

   assign hs_cmd = slv_cmd_valid & slv_cmd_ready;
   assign hs_rsp = slv_rsp_valid & slv_rsp_ready;

   // Bus cycle flags
   // Command on the same edge as the response keeps the flag set
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= '0;
      end else begin
         for (int i = 0; i < FB_NBUS; i++) begin
            if (hs_cmd[i]) begin
               pending[i] <= 1'b1;
            end else if (hs_rsp[i]) begin
               pending[i] <= 1'b0;
            end
         end
      end
   end

   // Command gating
   // Only one slave may own the bus at a time
   always_comb begin
      for (int j = 0; j < FB_NBUS; j++) begin
         accept[j] = ~|pending | pending[j];
      end
   end

   assign slv_cmd_valid = sel & accept & {FB_NBUS{cmd_valid}};
   assign cmd_ready_sel = sel & accept & slv_cmd_ready;
   assign cmd_ready     = |cmd_ready_sel;

   // Response merge
   // AND-OR tree over the pending slave
   assign rsp_valid = |(pending & slv_rsp_valid);

   always_comb begin
      rsp_data = '0;
      for (int k = 0; k < FB_NBUS; k++) begin
         rsp_data = rsp_data | ({$bits(fb_word_t){pending[k]}} & slv_rsp_data[k]);
      end
   end

   // Ready goes back only to the owner
   assign slv_rsp_ready = pending & {FB_NBUS{rsp_ready}};

endmodule

`default_nettype wire

//--- hw/fb_addr_decoder.sv
// Address decoder: maps the command address region to a one-hot slave select
`timescale 1ns/1ps
`default_nettype none

module fb_addr_decoder
   import fb_bus_pkg::*;
   import fb_map_pkg::*;
(
   input  fb_addr_t addr,
   output fb_sel_t  sel
);

   // Top nibble picks the region
   fb_region_t region;

   assign region = addr[31:28];

   always_comb begin
      sel = '0;
      case (region)
         REGION_SRAM: begin
            sel[SLV_SRAM] = 1'b1;
         end
         REGION_REGS: begin
            sel[SLV_REGS] = 1'b1;
         end
         // Unmapped space
         default: begin
            sel[SLV_DFLT] = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hw/fb_map_pkg.sv
// Frontend bus memory map: slave count, slave indices, region codes and default answer
`default_nettype none

package fb_map_pkg;

   // Number of slaves behind the router
   localparam int FB_NBUS = 3;

   // One-hot slave select
   typedef logic [FB_NBUS-1:0] fb_sel_t;

   // Region code, address bits 31 to 28
   typedef logic [3:0] fb_region_t;

   // Slave indices
   localparam int SLV_SRAM = 0;
   localparam int SLV_REGS = 1;
   localparam int SLV_DFLT = 2;

   // Mapped regions
   localparam fb_region_t REGION_SRAM = 4'h0;
   localparam fb_region_t REGION_REGS = 4'h1;
   // Everything else lands on the default slave

   // Answer word for unmapped accesses
   localparam fb_bus_pkg::fb_word_t DFLT_WORD = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

//--- hw/fb_bus_pkg.sv
// Frontend bus link types: word, address, byte mask, command struct and byte merge
`default_nettype none

package fb_bus_pkg;

   // Bytes per bus word
   localparam int FB_NBYTES = 4;

   // Data word
   typedef logic [8*FB_NBYTES-1:0] fb_word_t;
   // Byte address
   typedef logic [31:0] fb_addr_t;
   // Byte write mask, all zeros is a read
   typedef logic [FB_NBYTES-1:0] fb_mask_t;

   // Command, write data sampled together with the address
   typedef struct packed {
      fb_addr_t addr;
      fb_mask_t we_msk;
      fb_word_t wdata;
   } fb_cmd_t;

   // Old word with the enabled bytes replaced by new data
   function automatic fb_word_t fb_merge(fb_word_t old_word, fb_word_t new_word,
                                         fb_mask_t msk);
      fb_word_t res;
      res = old_word;
      for (int b = 0; b < FB_NBYTES; b++) begin
         if (msk[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage

`default_nettype wire
